//--- hw/noc_link_pkg.sv
// ==============================
// NoC link and flit types
// ==============================
`default_nettype none

package noc_link_pkg;

   localparam int x_cord_width_lp  = 4;
   localparam int y_cord_width_lp  = 4;
   localparam int flit_width_lp    = 32;
   localparam int payload_width_lp = flit_width_lp - y_cord_width_lp - x_cord_width_lp;

   // destination coordinates sit in the low bits
   typedef struct packed {
      logic [payload_width_lp-1:0] payload;
      logic [y_cord_width_lp-1:0]  y_cord;
      logic [x_cord_width_lp-1:0]  x_cord;
   } flit_s;

   // one direction of a port pair
   // ready_and_rev flows back against v and data
   typedef struct packed {
      logic  v;
      logic  ready_and_rev;
      flit_s data;
   } noc_link_s;

endpackage

`default_nettype wire

//--- hw/mesh_router_pkg.sv
// ==============================
// mesh router constants
// ==============================
`default_nettype none

package mesh_router_pkg;

   localparam int dirs_lp = 5;

   // port order P W E N S
   localparam int dir_p_lp = 0;
   localparam int dir_w_lp = 1;
   localparam int dir_e_lp = 2;
   localparam int dir_n_lp = 3;
   localparam int dir_s_lp = 4;

   localparam int dir_idx_width_lp = $clog2(dirs_lp);

   typedef logic [dirs_lp-1:0]          dir_vec_t;
   typedef logic [dir_idx_width_lp-1:0] dir_idx_t;

   // input buffer depth is kept a power of two
   localparam int fifo_els_lp = 2;

   typedef logic [$clog2(fifo_els_lp)-1:0]   fifo_ptr_t;
   typedef logic [$clog2(fifo_els_lp+1)-1:0] fifo_cnt_t;

   // row is the input, bit is the output
   // N and S never turn into X and nothing bounces back except P
   localparam dir_vec_t [dirs_lp-1:0] legal_turn_lp = {
      5'b01001,
      5'b10001,
      5'b11011,
      5'b11101,
      5'b11111
   };

endpackage

`default_nettype wire

//--- hw/mesh_router_in_fifo.sv
// ==============================
// router input FIFO
// ==============================
`timescale 1ns/10ps
`default_nettype none

module mesh_router_in_fifo (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                v_i,
   input  noc_link_pkg::flit_s data_i,
   output logic                ready_o,
   output logic                v_o,
   output noc_link_pkg::flit_s data_o,
   input  logic                yumi_i
);

   noc_link_pkg::flit_s        mem_r [mesh_router_pkg::fifo_els_lp];
   mesh_router_pkg::fifo_ptr_t rd_ptr_r;
   mesh_router_pkg::fifo_ptr_t wr_ptr_r;
   mesh_router_pkg::fifo_cnt_t count_r;
   mesh_router_pkg::fifo_cnt_t count_n;
   logic                       ready_r;
   logic                       enq;

   assign enq     = v_i & ready_r;
   assign ready_o = ready_r;
   assign v_o     = (count_r != '0);
   assign data_o  = mem_r[rd_ptr_r];

   always_comb begin
      count_n = count_r;
      if (enq && !yumi_i) begin
         count_n = count_r + 1'b1;
      end else if (yumi_i && !enq) begin
         count_n = count_r - 1'b1;
      end
   end

   // pointers wrap naturally at a power-of-two depth
   always_ff @(posedge clk_i) begin
      if (!reset_i) begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         count_r  <= '0;
         ready_r  <= 1'b0;
      end else begin
         if (enq) begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
         end
         if (yumi_i) begin
            rd_ptr_r <= rd_ptr_r + 1'b1;
         end
         count_r <= count_n;
         ready_r <= (count_n != mesh_router_pkg::fifo_els_lp);
      end
   end

   always_ff @(posedge clk_i) begin
      if (enq) begin
         mem_r[wr_ptr_r] <= data_i;
      end
   end

   // a refused flit must still be offered on the next edge
   a_sender_holds_v: assert property (@(posedge clk_i) disable iff (!reset_i)
      v_i && !ready_o |=> v_i);

   // arbiters only dequeue a head that exists
   a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (!reset_i)
      yumi_i |-> v_o);

endmodule

`default_nettype wire

//--- hw/mesh_router_route_calc.sv
// ==============================
// XY route decode
// ==============================
`timescale 1ns/10ps
`default_nettype none

module mesh_router_route_calc (
   input  mesh_router_pkg::dir_vec_t                                fifo_v_i,
   input  noc_link_pkg::flit_s [mesh_router_pkg::dirs_lp-1:0]       fifo_data_i,
   input  logic [noc_link_pkg::x_cord_width_lp-1:0]                 my_x_i,
   input  logic [noc_link_pkg::y_cord_width_lp-1:0]                 my_y_i,
   output mesh_router_pkg::dir_vec_t [mesh_router_pkg::dirs_lp-1:0] req_o
);

   // X is resolved first, then Y, then local delivery
   always_comb begin
      req_o = '0;
      for (int i = 0; i < mesh_router_pkg::dirs_lp; i++) begin
         if (fifo_v_i[i]) begin
            if (fifo_data_i[i].x_cord > my_x_i) begin
               req_o[i][mesh_router_pkg::dir_e_lp] = 1'b1;
            end else if (fifo_data_i[i].x_cord < my_x_i) begin
               req_o[i][mesh_router_pkg::dir_w_lp] = 1'b1;
            end else if (fifo_data_i[i].y_cord > my_y_i) begin
               req_o[i][mesh_router_pkg::dir_s_lp] = 1'b1;
            end else if (fifo_data_i[i].y_cord < my_y_i) begin
               req_o[i][mesh_router_pkg::dir_n_lp] = 1'b1;
            end else begin
               req_o[i][mesh_router_pkg::dir_p_lp] = 1'b1;
            end
         end
      end
   end

   // a bad turn means a neighbour broke XY order
   always_comb begin
      for (int i = 0; i < mesh_router_pkg::dirs_lp; i++) begin
         assert ((req_o[i] & ~mesh_router_pkg::legal_turn_lp[i]) == '0)
            else $error("illegal turn from input %0d, request %b", i, req_o[i]);
      end
   end

endmodule

`default_nettype wire

//--- hw/mesh_router_out_arb.sv
// ==============================
// router output arbiter
// ==============================
`timescale 1ns/10ps
`default_nettype none

module mesh_router_out_arb (
   input  logic                                               clk_i,
   input  logic                                               reset_i,
   input  mesh_router_pkg::dir_vec_t                          req_i,
   input  noc_link_pkg::flit_s [mesh_router_pkg::dirs_lp-1:0] data_i,
   input  logic                                               ready_and_i,
   output logic                                               v_o,
   output noc_link_pkg::flit_s                                data_o,
   output mesh_router_pkg::dir_vec_t                          grant_o
);

   mesh_router_pkg::dir_idx_t ptr_r;
   mesh_router_pkg::dir_idx_t win_idx;
   logic                      xfer;

   // first requester at or after the pointer
   always_comb begin
      int   cand;
      logic found;
      win_idx = ptr_r;
      found   = 1'b0;
      for (int k = 0; k < mesh_router_pkg::dirs_lp; k++) begin
         cand = (int'(ptr_r) + k) % mesh_router_pkg::dirs_lp;
         if (!found && req_i[cand]) begin
            win_idx = mesh_router_pkg::dir_idx_t'(cand);
            found   = 1'b1;
         end
      end
   end

   assign v_o    = |req_i;
   assign data_o = data_i[win_idx];
   assign xfer   = v_o & ready_and_i;

   always_comb begin
      grant_o = '0;
      if (xfer) begin
         grant_o[win_idx] = 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!reset_i) begin
         ptr_r <= '0;
      end else if (xfer) begin
         if (win_idx == mesh_router_pkg::dir_idx_t'(mesh_router_pkg::dirs_lp - 1)) begin
            ptr_r <= '0;
         end else begin
            ptr_r <= win_idx + 1'b1;
         end
      end else if (v_o) begin
         // park on the stalled winner so a later request cannot take its slot
         ptr_r <= win_idx;
      end
   end

   // only a requesting input may be dequeued
   a_grant_to_req: assert property (@(posedge clk_i) disable iff (!reset_i)
      (grant_o & ~req_i) == '0);

   // the winning FIFO must keep its head while the link is stalled
   a_stall_stable: assert property (@(posedge clk_i) disable iff (!reset_i)
      v_o && !ready_and_i |=> v_o && $stable(data_o));

endmodule

`default_nettype wire

//--- hw/mesh_router_buffered.sv
// ==============================
// buffered mesh router
// ==============================
`timescale 1ns/10ps
`default_nettype none

module mesh_router_buffered (
   input  logic                                                      clk_i,
   input  logic                                                      reset_i,
   input  noc_link_pkg::noc_link_s [mesh_router_pkg::dirs_lp-1:0]    link_i,
   output noc_link_pkg::noc_link_s [mesh_router_pkg::dirs_lp-1:0]    link_o,
   input  logic [noc_link_pkg::x_cord_width_lp-1:0]                  my_x_i,
   input  logic [noc_link_pkg::y_cord_width_lp-1:0]                  my_y_i
);

   mesh_router_pkg::dir_vec_t                                fifo_v;
   mesh_router_pkg::dir_vec_t                                fifo_ready;
   mesh_router_pkg::dir_vec_t                                fifo_yumi;
   noc_link_pkg::flit_s [mesh_router_pkg::dirs_lp-1:0]       fifo_data;
   // req by input, out_req and grant by output
   mesh_router_pkg::dir_vec_t [mesh_router_pkg::dirs_lp-1:0] req;
   mesh_router_pkg::dir_vec_t [mesh_router_pkg::dirs_lp-1:0] out_req;
   mesh_router_pkg::dir_vec_t [mesh_router_pkg::dirs_lp-1:0] grant;
   mesh_router_pkg::dir_vec_t                                out_v;
   noc_link_pkg::flit_s [mesh_router_pkg::dirs_lp-1:0]       out_data;

   for (genvar d = 0; d < mesh_router_pkg::dirs_lp; d++) begin : g_in
      mesh_router_in_fifo i_in_fifo (
         .clk_i   (clk_i),
         .reset_i (reset_i),
         .v_i     (link_i[d].v),
         .data_i  (link_i[d].data),
         .ready_o (fifo_ready[d]),
         .v_o     (fifo_v[d]),
         .data_o  (fifo_data[d]),
         .yumi_i  (fifo_yumi[d])
      );
   end

   mesh_router_route_calc i_route_calc (
      .fifo_v_i    (fifo_v),
      .fifo_data_i (fifo_data),
      .my_x_i      (my_x_i),
      .my_y_i      (my_y_i),
      .req_o       (req)
   );

   // transpose requests to outputs and grants back to inputs
   always_comb begin
      fifo_yumi = '0;
      for (int o = 0; o < mesh_router_pkg::dirs_lp; o++) begin
         for (int i = 0; i < mesh_router_pkg::dirs_lp; i++) begin
            out_req[o][i] = req[i][o];
            fifo_yumi[i]  = fifo_yumi[i] | grant[o][i];
         end
      end
   end

   for (genvar d = 0; d < mesh_router_pkg::dirs_lp; d++) begin : g_out
      mesh_router_out_arb i_out_arb (
         .clk_i       (clk_i),
         .reset_i     (reset_i),
         .req_i       (out_req[d]),
         .data_i      (fifo_data),
         .ready_and_i (link_i[d].ready_and_rev),
         .v_o         (out_v[d]),
         .data_o      (out_data[d]),
         .grant_o     (grant[d])
      );
   end

   always_comb begin
      for (int d = 0; d < mesh_router_pkg::dirs_lp; d++) begin
         link_o[d].v             = out_v[d];
         link_o[d].ready_and_rev = fifo_ready[d];
         link_o[d].data          = out_data[d];
      end
   end

endmodule

`default_nettype wire

//--- verif/tb_mesh_router.sv
// ==============================
// mesh router testbench
// ==============================
`timescale 1ns/10ps
`default_nettype none

module tb_mesh_router;

   logic                                                   clk_i = 1'b0;
   logic                                                   reset_i;
   noc_link_pkg::noc_link_s [mesh_router_pkg::dirs_lp-1:0] link_i;
   noc_link_pkg::noc_link_s [mesh_router_pkg::dirs_lp-1:0] link_o;

   // one expected queue per input and output pair in input-major order
   noc_link_pkg::flit_s exp_q [mesh_router_pkg::dirs_lp*mesh_router_pkg::dirs_lp][$];
   noc_link_pkg::flit_s gen_q [mesh_router_pkg::dirs_lp][$];
   int                  n_log [$];
   logic [31:0]         lcg_state = 32'h42a0_8d58;
   string               cur_test;
   int                  pending;
   int                  seq_no;
   int                  err_cnt;
   int                  chk_cnt;
   int                  test_cnt;
   int                  test_err;
   int                  wait_limit = 500;

   mesh_router_buffered i_mesh_router_buffered (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .link_i  (link_i),
      .link_o  (link_o),
      .my_x_i  (4'd5),
      .my_y_i  (4'd5)
   );

   always #2 clk_i = ~clk_i;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // X first, then Y, around the router at (5, 5)
   function automatic int xy_output(noc_link_pkg::flit_s f);
      if (f.x_cord != 4'd5) begin
         return (f.x_cord > 4'd5) ? mesh_router_pkg::dir_e_lp : mesh_router_pkg::dir_w_lp;
      end
      if (f.y_cord != 4'd5) begin
         return (f.y_cord > 4'd5) ? mesh_router_pkg::dir_s_lp : mesh_router_pkg::dir_n_lp;
      end
      return mesh_router_pkg::dir_p_lp;
   endfunction

   function automatic logic turn_ok(int i, int o);
      logic ns_in;
      logic x_out;
      ns_in = (i == mesh_router_pkg::dir_n_lp) || (i == mesh_router_pkg::dir_s_lp);
      x_out = (o == mesh_router_pkg::dir_w_lp) || (o == mesh_router_pkg::dir_e_lp);
      return !(ns_in && x_out) && ((i != o) || (i == mesh_router_pkg::dir_p_lp));
   endfunction

   // source input sits in the top payload bits
   function automatic noc_link_pkg::flit_s make_flit(int src, int x, int y);
      noc_link_pkg::flit_s f;
      f.payload = {3'(src), 21'(seq_no)};
      f.y_cord  = 4'(y);
      f.x_cord  = 4'(x);
      seq_no++;
      return f;
   endfunction

   function automatic mesh_router_pkg::dir_vec_t out_bits(logic ready_sel);
      mesh_router_pkg::dir_vec_t b;
      for (int d = 0; d < mesh_router_pkg::dirs_lp; d++) begin
         b[d] = ready_sel ? link_o[d].ready_and_rev : link_o[d].v;
      end
      return b;
   endfunction

   task automatic tick();
      @(posedge clk_i);
      #0.5;
   endtask

   task automatic timed_out(string what);
      $display("timeout in test %s: %s", cur_test, what);
      $display("Checks failed");
      $finish;
   endtask

   task automatic begin_test(string name);
      cur_test = name;
      test_err = err_cnt;
      test_cnt++;
   endtask

   task automatic wait_drain();
      int tmo;
      tmo = 0;
      while (pending != 0) begin
         tick();
         tmo++;
         if (tmo > wait_limit) begin
            timed_out("expected flits never left the router");
         end
      end
   endtask

   task automatic end_test();
      wait_drain();
      $display("test %s finished with %0d errors", cur_test, err_cnt - test_err);
   endtask

   // scoreboard samples mid-cycle where v and ready are settled
   task automatic monitor_outputs();
      int src;
      int idx;
      forever begin
         @(negedge clk_i);
         for (int o = 0; o < mesh_router_pkg::dirs_lp; o++) begin
            if (reset_i && link_o[o].v && link_i[o].ready_and_rev) begin
               src = int'(link_o[o].data.payload[23:21]);
               idx = src * mesh_router_pkg::dirs_lp + o;
               chk_cnt++;
               if (src >= mesh_router_pkg::dirs_lp || exp_q[idx].size() == 0) begin
                  $display("%s: output %0d sent flit %h that was never expected there",
                           cur_test, o, link_o[o].data);
                  err_cnt++;
               end else begin
                  if (link_o[o].data !== exp_q[idx][0]) begin
                     $display("ERR %s: output %0d expected %h, actual %h",
                              cur_test, o, exp_q[idx][0], link_o[o].data);
                     err_cnt++;
                  end
                  void'(exp_q[idx].pop_front());
                  pending--;
                  if (o == mesh_router_pkg::dir_n_lp) begin
                     n_log.push_back(src);
                  end
               end
            end
         end
      end
   endtask

   task automatic send_flit(int d, noc_link_pkg::flit_s f);
      int   tmo;
      logic taken;
      tmo   = 0;
      taken = 1'b0;
      exp_q[d * mesh_router_pkg::dirs_lp + xy_output(f)].push_back(f);
      pending++;
      link_i[d].v    = 1'b1;
      link_i[d].data = f;
      while (!taken) begin
         @(negedge clk_i);
         taken = link_o[d].ready_and_rev;
         tick();
         tmo++;
         if (!taken && tmo > wait_limit) begin
            timed_out($sformatf("input %0d never accepted flit %h", d, f));
         end
      end
      link_i[d].v = 1'b0;
   endtask

   task automatic send_queue(int d);
      while (gen_q[d].size() != 0) begin
         send_flit(d, gen_q[d].pop_front());
      end
   endtask

   task automatic reset_outputs();
      begin_test("reset");
      repeat (3) begin
         @(negedge clk_i);
         chk_cnt++;
         if (out_bits(1'b0) != '0) begin
            $display("ERR %s: link_o v expected 00000, actual %b", cur_test, out_bits(1'b0));
            err_cnt++;
         end
      end
      tick();
      reset_i = 1'b1;
      tick();
      @(negedge clk_i);
      chk_cnt++;
      if (out_bits(1'b1) != '1 || out_bits(1'b0) != '0) begin
         $display("ERR %s: ready/v expected 11111/00000, actual %b/%b",
                  cur_test, out_bits(1'b1), out_bits(1'b0));
         err_cnt++;
      end
      tick();
      end_test();
   endtask

   task automatic route_each_dir();
      begin_test("route");
      send_flit(mesh_router_pkg::dir_p_lp, make_flit(0, 9, 5));
      send_flit(mesh_router_pkg::dir_p_lp, make_flit(0, 8, 2));
      send_flit(mesh_router_pkg::dir_p_lp, make_flit(0, 2, 5));
      send_flit(mesh_router_pkg::dir_p_lp, make_flit(0, 1, 9));
      send_flit(mesh_router_pkg::dir_p_lp, make_flit(0, 5, 1));
      send_flit(mesh_router_pkg::dir_p_lp, make_flit(0, 5, 12));
      send_flit(mesh_router_pkg::dir_p_lp, make_flit(0, 5, 5));
      end_test();
   endtask

   task automatic shared_output();
      int last_pos [mesh_router_pkg::dirs_lp];
      begin_test("contention");
      n_log.delete();
      fork
         repeat (3) send_flit(mesh_router_pkg::dir_w_lp, make_flit(1, 5, 1));
         repeat (3) send_flit(mesh_router_pkg::dir_e_lp, make_flit(2, 5, 1));
         repeat (3) send_flit(mesh_router_pkg::dir_p_lp, make_flit(0, 5, 1));
      join
      wait_drain();
      chk_cnt++;
      if (n_log.size() != 9) begin
         $display("ERR %s: N transfers expected 9, actual %0d", cur_test, n_log.size());
         err_cnt++;
      end
      for (int s = 0; s < mesh_router_pkg::dirs_lp; s++) begin
         last_pos[s] = -1;
      end
      // at most two other winners between two turns of one input
      for (int k = 0; k < n_log.size(); k++) begin
         chk_cnt++;
         if (k - last_pos[n_log[k]] > 3) begin
            $display("%s: input %0d waited through %0d other transfers on N",
                     cur_test, n_log[k], k - last_pos[n_log[k]] - 1);
            err_cnt++;
         end
         last_pos[n_log[k]] = k;
      end
      end_test();
   endtask

   task automatic stalled_output();
      noc_link_pkg::flit_s fe [3];
      noc_link_pkg::flit_s fn;
      int                  tmo;
      begin_test("backpressure");
      link_i[mesh_router_pkg::dir_e_lp].ready_and_rev = 1'b0;
      for (int k = 0; k < 3; k++) begin
         fe[k] = make_flit(0, 10, 5);
      end
      fn = make_flit(4, 5, 2);
      send_flit(mesh_router_pkg::dir_p_lp, fe[0]);
      send_flit(mesh_router_pkg::dir_p_lp, fe[1]);
      fork
         send_flit(mesh_router_pkg::dir_p_lp, fe[2]);
         begin
            @(negedge clk_i);
            chk_cnt++;
            if (link_o[mesh_router_pkg::dir_p_lp].ready_and_rev) begin
               $display("%s: P input still ready with two flits buffered", cur_test);
               err_cnt++;
            end
            tick();
            send_flit(mesh_router_pkg::dir_s_lp, fn);
            tmo = 0;
            while (exp_q[mesh_router_pkg::dir_s_lp * 5 + mesh_router_pkg::dir_n_lp].size()) begin
               @(negedge clk_i);
               chk_cnt++;
               if (!link_o[mesh_router_pkg::dir_e_lp].v ||
                   link_o[mesh_router_pkg::dir_e_lp].data !== fe[0]) begin
                  $display("ERR %s: stalled E output expected %h, actual %h",
                           cur_test, fe[0], link_o[mesh_router_pkg::dir_e_lp].data);
                  err_cnt++;
               end
               tick();
               tmo++;
               if (tmo > wait_limit) begin
                  timed_out("N-bound flit from S was blocked by the stalled E output");
               end
            end
            link_i[mesh_router_pkg::dir_e_lp].ready_and_rev = 1'b1;
         end
      join
      end_test();
   endtask

   task automatic random_traffic();
      noc_link_pkg::flit_s f;
      logic [31:0]         r;
      int                  src;
      int                  cyc;
      logic                running;
      begin_test("random");
      for (int k = 0; k < 60; k++) begin
         src = int'((lcg_next() >> 16) % 32'd5);
         do begin
            f = make_flit(src, int'(3 + (lcg_next() >> 16) % 32'd5),
                          int'(3 + (lcg_next() >> 16) % 32'd5));
         end while (!turn_ok(src, xy_output(f)));
         gen_q[src].push_back(f);
      end
      running = 1'b1;
      cyc     = 0;
      fork
         begin
            fork
               send_queue(mesh_router_pkg::dir_p_lp);
               send_queue(mesh_router_pkg::dir_w_lp);
               send_queue(mesh_router_pkg::dir_e_lp);
               send_queue(mesh_router_pkg::dir_n_lp);
               send_queue(mesh_router_pkg::dir_s_lp);
            join
            running = 1'b0;
         end
         while (running) begin
            for (int o = 0; o < mesh_router_pkg::dirs_lp; o++) begin
               r = lcg_next();
               link_i[o].ready_and_rev = r[28] | r[29];
            end
            tick();
            cyc++;
            if (cyc > 10 * wait_limit) begin
               timed_out("random senders did not finish");
            end
         end
      join
      for (int o = 0; o < mesh_router_pkg::dirs_lp; o++) begin
         link_i[o].ready_and_rev = 1'b1;
      end
      end_test();
   endtask

   initial begin
      reset_i  = 1'b0;
      link_i   = '0;
      pending  = 0;
      seq_no   = 0;
      err_cnt  = 0;
      chk_cnt  = 0;
      test_cnt = 0;
      for (int o = 0; o < mesh_router_pkg::dirs_lp; o++) begin
         link_i[o].ready_and_rev = 1'b1;
      end
      fork
         monitor_outputs();
      join_none
      reset_outputs();
      route_each_dir();
      shared_output();
      stalled_output();
      random_traffic();
      $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
hw/noc_link_pkg.sv
hw/mesh_router_pkg.sv
hw/mesh_router_in_fifo.sv
hw/mesh_router_route_calc.sv
hw/mesh_router_out_arb.sv
hw/mesh_router_buffered.sv
verif/tb_mesh_router.sv

//--- Makefile
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_mesh_router: flist.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_mesh_router -f flist.f

run: obj_dir/Vtb_mesh_router
	@out="$$(./obj_dir/Vtb_mesh_router)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^All checks passed$$"

clean:
	rm -rf obj_dir
